// ==== logic/mdu_pkg.sv ====
package mdu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_id_t;

    // queue geometry and port counts
    localparam int IQ_SIZE    = 8;
    localparam int IQ_PTR_W   = 3;
    localparam int DISP_COUNT = 2;
    localparam int CDB_COUNT  = 2;

    // divider runs one quotient bit per step
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = 5;

    typedef enum logic [2:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_MOD,
        OP_MODU
    } mdu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        DIV,
        DONE
    } exec_state_e;

    // ------------------------------------------------------------------
    // dispatch side records
    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        word_t   value;
    } operand_t;

    typedef struct packed {
        logic           valid;
        mdu_op_e        op;
        rob_id_t        dest;
        operand_t [1:0] src;
    } disp_pkt_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    // ------------------------------------------------------------------
    // pipeline records, queue -> decode -> execute -> result -> output
    typedef struct packed {
        mdu_op_e     op;
        rob_id_t     dest;
        word_t [1:0] src;
    } mdu_req_t;

    typedef struct packed {
        rob_id_t dest;
        logic    is_div;
        logic    want_high;
        logic    negate_result;
        logic    div_by_zero;
        word_t   mag_a;
        word_t   mag_b;
    } mdu_ctrl_t;

    typedef struct packed {
        rob_id_t dest;
        logic    is_div;
        logic    want_high;
        logic    negate_result;
        logic    div_by_zero;
        word_t   dividend;
        word_t   hi;
        word_t   lo;
    } mdu_raw_t;

    typedef struct packed {
        rob_id_t dest;
        word_t   data;
    } mdu_res_t;

endpackage

// ==== logic/mdu_iq_entry.sv ====
module mdu_iq_entry (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   flush_i,
    input  logic                                   init_i,
    input  mdu_pkg::disp_pkt_t                     pkt_i,
    input  mdu_pkg::cdb_t [mdu_pkg::CDB_COUNT-1:0] cdb_i,
    input  logic                                   clear_i,
    output logic                                   busy_o,
    output logic                                   ready_o,
    output mdu_pkg::mdu_req_t                      req_o
);
    import mdu_pkg::*;

    logic           busy_q;
    mdu_op_e        op_q;
    rob_id_t        dest_q;
    operand_t [1:0] src_q;

    // first matching broadcast wins
    function automatic operand_t wake(operand_t opnd, cdb_t [CDB_COUNT-1:0] cdb);
        operand_t res;
        res = opnd;
        for (int p = 0; p < CDB_COUNT; p++) begin
            if (!res.ready && cdb[p].valid && cdb[p].tag == res.tag) begin
                res.ready = 1'b1;
                res.value = cdb[p].data;
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (init_i) begin
            busy_q <= 1'b1;
        end else if (clear_i) begin
            busy_q <= 1'b0;
        end
    end

    // operands that are still waiting snoop the cdb every cycle
    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q   <= pkt_i.op;
            dest_q <= pkt_i.dest;
            for (int s = 0; s < 2; s++) begin
                src_q[s] <= wake(pkt_i.src[s], cdb_i);
            end
        end else if (busy_q) begin
            for (int s = 0; s < 2; s++) begin
                src_q[s] <= wake(src_q[s], cdb_i);
            end
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && src_q[0].ready && src_q[1].ready;

    always_comb begin
        req_o.op     = op_q;
        req_o.dest   = dest_q;
        req_o.src[0] = src_q[0].value;
        req_o.src[1] = src_q[1].value;
    end

endmodule

// ==== logic/mdu_issue_queue.sv ====
module mdu_issue_queue (
    input  logic                                           clk,
    input  logic                                           reset_i,
    input  logic                                           flush_i,
    input  mdu_pkg::disp_pkt_t [mdu_pkg::DISP_COUNT-1:0]   disp_i,
    input  mdu_pkg::cdb_t [mdu_pkg::CDB_COUNT-1:0]         cdb_i,
    input  logic                                           accept_i,
    output logic                                           dispatch_ready_o,
    output mdu_pkg::mdu_req_t                              issue_o,
    output logic                                           issue_valid_o
);
    import mdu_pkg::*;

    logic [IQ_PTR_W-1:0] head_q;
    logic [IQ_PTR_W-1:0] tail_q;
    logic [IQ_PTR_W-1:0] tail_next;
    logic [IQ_PTR_W:0]   free_q;
    logic [IQ_PTR_W:0]   free_d;
    logic                disp0;
    logic                disp1;
    logic [1:0]          n_disp;
    logic                issue;

    logic      [IQ_SIZE-1:0] entry_init;
    logic      [IQ_SIZE-1:0] entry_clear;
    logic      [IQ_SIZE-1:0] entry_busy;
    logic      [IQ_SIZE-1:0] entry_ready;
    disp_pkt_t [IQ_SIZE-1:0] entry_pkt;
    mdu_req_t  [IQ_SIZE-1:0] entry_req;

    // ------------------------------------------------------------------
    // pointers and free count
    assign disp0     = disp_i[0].valid && dispatch_ready_o;
    assign disp1     = disp_i[1].valid && dispatch_ready_o;
    assign n_disp    = 2'(disp0) + 2'(disp1);
    assign tail_next = tail_q + 1'b1;

    // strictly in order, only the head may leave
    assign issue         = entry_ready[head_q] && accept_i;
    assign issue_valid_o = issue;
    assign issue_o       = entry_req[head_q];

    assign free_d = free_q - (IQ_PTR_W+1)'(n_disp) + (IQ_PTR_W+1)'(issue);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            free_q           <= (IQ_PTR_W+1)'(IQ_SIZE);
            dispatch_ready_o <= 1'b1;
        end else begin
            head_q           <= head_q + IQ_PTR_W'(issue);
            tail_q           <= tail_q + IQ_PTR_W'(n_disp);
            free_q           <= free_d;
            // room for a full pair next cycle
            dispatch_ready_o <= free_d >= (IQ_PTR_W+1)'(2);
        end
    end

    // ------------------------------------------------------------------
    // slot 0 goes to tail, slot 1 to tail + 1
    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            entry_init[i]  = 1'b0;
            entry_pkt[i]   = disp_i[0];
            entry_clear[i] = issue && (head_q == IQ_PTR_W'(i));
            if (tail_q == IQ_PTR_W'(i)) begin
                entry_init[i] = disp0;
            end else if (tail_next == IQ_PTR_W'(i)) begin
                entry_init[i] = disp1;
                entry_pkt[i]  = disp_i[1];
            end
        end
    end

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        mdu_iq_entry u_entry (
            .clk     (clk),
            .reset_i (reset_i),
            .flush_i (flush_i),
            .init_i  (entry_init[i]),
            .pkt_i   (entry_pkt[i]),
            .cdb_i   (cdb_i),
            .clear_i (entry_clear[i]),
            .busy_o  (entry_busy[i]),
            .ready_o (entry_ready[i]),
            .req_o   (entry_req[i])
        );
    end

    // ------------------------------------------------------------------
    a_disp_when_ready: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        (disp_i[0].valid || disp_i[1].valid) |-> dispatch_ready_o)
        else $error("dispatch while dispatch_ready_o is low");

    a_free_bound: assert property (@(posedge clk) disable iff (reset_i)
        free_q <= (IQ_PTR_W+1)'(IQ_SIZE))
        else $error("free count above queue size");

    // counter and entry occupancy must agree
    a_free_matches_busy: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        int'(free_q) + $countones(entry_busy) == IQ_SIZE)
        else $error("free count out of step with busy entries");

endmodule

// ==== logic/mdu_op_decode.sv ====
module mdu_op_decode (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  mdu_pkg::mdu_req_t  req_i,
    input  logic               req_valid_i,
    input  logic               start_ready_i,
    output logic               accept_o,
    output mdu_pkg::mdu_ctrl_t ctrl_o,
    output logic               ctrl_valid_o
);
    import mdu_pkg::*;

    logic      valid_q;
    mdu_ctrl_t ctrl_q;
    mdu_ctrl_t ctrl;
    word_t     a;
    word_t     b;
    logic      is_signed;
    logic      sign_a;
    logic      sign_b;
    logic      neg;

    always_comb begin
        a         = req_i.src[0];
        b         = req_i.src[1];
        is_signed = req_i.op inside {OP_MULH, OP_DIV, OP_MOD};
        sign_a    = is_signed && a[31];
        sign_b    = is_signed && b[31];
        case (req_i.op)
            OP_MULH, OP_DIV: neg = sign_a ^ sign_b;
            // remainder follows the dividend
            OP_MOD:          neg = sign_a;
            default:         neg = 1'b0;
        endcase

        ctrl.dest          = req_i.dest;
        ctrl.is_div        = req_i.op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
        ctrl.want_high     = req_i.op inside {OP_MULH, OP_MULHU, OP_MOD, OP_MODU};
        ctrl.div_by_zero   = ctrl.is_div && (b == '0);
        ctrl.negate_result = neg && !ctrl.div_by_zero;
        // the raw dividend is kept for the fixed div-by-zero remainder
        ctrl.mag_a         = (sign_a && !ctrl.div_by_zero) ? -a : a;
        ctrl.mag_b         = sign_b ? -b : b;
    end

    assign accept_o = !valid_q || start_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (accept_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o && req_valid_i) begin
            ctrl_q <= ctrl;
        end
    end

    assign ctrl_o       = ctrl_q;
    assign ctrl_valid_o = valid_q;

endmodule

// ==== logic/mdu_execute.sv ====
module mdu_execute (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  mdu_pkg::mdu_ctrl_t ctrl_i,
    input  logic               ctrl_valid_i,
    input  logic               take_i,
    output logic               start_ready_o,
    output mdu_pkg::mdu_raw_t  raw_o,
    output logic               done_o
);
    import mdu_pkg::*;

    exec_state_e          state_q;
    mdu_ctrl_t            ctrl_q;
    word_t                hi_q;
    word_t                lo_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic                 start;

    logic [63:0] prod;
    logic [32:0] trial;
    logic [32:0] diff;
    logic        q_bit;
    word_t       rem_next;

    assign start_ready_o = (state_q == IDLE);
    assign start         = start_ready_o && ctrl_valid_i;
    assign done_o        = (state_q == DONE);

    // ------------------------------------------------------------------
    // datapath
    assign prod = 64'(ctrl_q.mag_a) * 64'(ctrl_q.mag_b);

    // restoring step, hi holds the partial remainder, lo shifts the dividend out
    assign trial    = {hi_q, lo_q[31]};
    assign diff     = trial - {1'b0, ctrl_q.mag_b};
    assign q_bit    = !diff[32];
    assign rem_next = q_bit ? diff[31:0] : trial[31:0];

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ctrl_valid_i) begin
                        if (!ctrl_i.is_div) begin
                            state_q <= MUL;
                        end else if (ctrl_i.div_by_zero) begin
                            state_q <= DONE;
                        end else begin
                            state_q <= DIV;
                        end
                    end
                end
                MUL:     state_q <= DONE;
                DIV: begin
                    if (cnt_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (take_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ctrl_q <= ctrl_i;
            cnt_q  <= '0;
            hi_q   <= '0;
            // div by zero lands directly on the all-ones quotient
            lo_q   <= ctrl_i.div_by_zero ? '1 : ctrl_i.mag_a;
        end else if (state_q == MUL) begin
            {hi_q, lo_q} <= prod;
        end else if (state_q == DIV) begin
            hi_q  <= rem_next;
            lo_q  <= {lo_q[30:0], q_bit};
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_comb begin
        raw_o.dest          = ctrl_q.dest;
        raw_o.is_div        = ctrl_q.is_div;
        raw_o.want_high     = ctrl_q.want_high;
        raw_o.negate_result = ctrl_q.negate_result;
        raw_o.div_by_zero   = ctrl_q.div_by_zero;
        // only meaningful on div by zero, where decode left it unsigned
        raw_o.dividend      = ctrl_q.mag_a;
        raw_o.hi            = hi_q;
        raw_o.lo            = lo_q;
    end

    a_done_held: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        done_o && !take_i |=> done_o)
        else $error("done dropped before take");

endmodule

// ==== logic/mdu_result.sv ====
module mdu_result (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              flush_i,
    input  mdu_pkg::mdu_raw_t raw_i,
    input  logic              done_i,
    input  logic              ready_i,
    output logic              take_o,
    output mdu_pkg::mdu_res_t res_o,
    output logic              valid_o
);
    import mdu_pkg::*;

    logic        valid_q;
    mdu_res_t    res_q;
    logic [63:0] prod;
    logic [63:0] prod_fix;
    word_t       mul_word;
    word_t       div_word;
    word_t       div_fix;

    // sign fix on the full product so the high half carries correctly
    assign prod     = {raw_i.hi, raw_i.lo};
    assign prod_fix = raw_i.negate_result ? -prod : prod;
    assign mul_word = raw_i.want_high ? prod_fix[63:32] : prod_fix[31:0];

    assign div_word = !raw_i.want_high  ? raw_i.lo :
                      raw_i.div_by_zero ? raw_i.dividend : raw_i.hi;
    assign div_fix  = raw_i.negate_result ? -div_word : div_word;

    assign take_o = !valid_q || ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (take_o) begin
            valid_q <= done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take_o && done_i) begin
            res_q.dest <= raw_i.dest;
            res_q.data <= raw_i.is_div ? div_fix : mul_word;
        end
    end

    assign res_o   = res_q;
    assign valid_o = valid_q;

    a_res_stable: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        valid_o && !ready_i |=> valid_o && $stable(res_o))
        else $error("result changed while stalled");

endmodule

// ==== logic/mdu_top.sv ====
module mdu_top (
    input  logic                                         clk,
    input  logic                                         reset_i,
    input  logic                                         flush_i,
    input  mdu_pkg::disp_pkt_t [mdu_pkg::DISP_COUNT-1:0] disp_i,
    input  mdu_pkg::cdb_t [mdu_pkg::CDB_COUNT-1:0]       cdb_i,
    input  logic                                         result_ready_i,
    output logic                                         dispatch_ready_o,
    output mdu_pkg::mdu_res_t                            result_o,
    output logic                                         result_valid_o
);
    import mdu_pkg::*;

    mdu_req_t  issue;
    logic      issue_valid;
    logic      accept;
    mdu_ctrl_t ctrl;
    logic      ctrl_valid;
    logic      start_ready;
    mdu_raw_t  raw;
    logic      done;
    logic      take;

    mdu_issue_queue u_issue_queue (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .disp_i           (disp_i),
        .cdb_i            (cdb_i),
        .accept_i         (accept),
        .dispatch_ready_o (dispatch_ready_o),
        .issue_o          (issue),
        .issue_valid_o    (issue_valid)
    );

    mdu_op_decode u_op_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .req_i         (issue),
        .req_valid_i   (issue_valid),
        .start_ready_i (start_ready),
        .accept_o      (accept),
        .ctrl_o        (ctrl),
        .ctrl_valid_o  (ctrl_valid)
    );

    mdu_execute u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .ctrl_i        (ctrl),
        .ctrl_valid_i  (ctrl_valid),
        .take_i        (take),
        .start_ready_o (start_ready),
        .raw_o         (raw),
        .done_o        (done)
    );

    mdu_result u_result (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .raw_i   (raw),
        .done_i  (done),
        .ready_i (result_ready_i),
        .take_o  (take),
        .res_o   (result_o),
        .valid_o (result_valid_o)
    );

endmodule

// ==== dv/mdu_tb.sv ====
module mdu_tb;
    import mdu_pkg::*;

    localparam int WAIT_LIMIT = 4000;

    logic                       clk;
    logic                       reset_i;
    logic                       flush_i;
    disp_pkt_t [DISP_COUNT-1:0] disp_i;
    cdb_t [CDB_COUNT-1:0]       cdb_i;
    logic                       result_ready_i;
    logic                       dispatch_ready_o;
    mdu_res_t                   result_o;
    logic                       result_valid_o;

    logic [31:0] lfsr_q;
    word_t       exp_data [64];
    rob_id_t     order_q [$];
    rob_id_t     next_tag;
    rob_id_t     exp_tag;
    int          errors;
    int          checked;

    mdu_top u_mdu_top (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .disp_i           (disp_i),
        .cdb_i            (cdb_i),
        .result_ready_i   (result_ready_i),
        .dispatch_ready_o (dispatch_ready_o),
        .result_o         (result_o),
        .result_valid_o   (result_valid_o)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // reference model and random source
    function automatic word_t ref_result(mdu_op_e op, word_t a, word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        full;
        word_t              res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        full = '0;
        case (op)
            OP_MUL:  res = a * b;
            OP_MULH: begin
                full = sa * sb;
                res  = full[63:32];
            end
            OP_MULHU: begin
                full = {32'd0, a} * {32'd0, b};
                res  = full[63:32];
            end
            OP_DIV: begin
                if (b == '0) begin
                    res = '1;
                end else begin
                    full = sa / sb;
                    res  = full[31:0];
                end
            end
            OP_DIVU: res = (b == '0) ? '1 : a / b;
            // remainder takes the dividend's sign
            OP_MOD: begin
                if (b == '0) begin
                    res = a;
                end else begin
                    full = sa % sb;
                    res  = full[31:0];
                end
            end
            OP_MODU: res = (b == '0) ? a : a % b;
            default: res = '0;
        endcase
        return res;
    endfunction

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic mdu_op_e rand_op();
        logic [2:0] v;
        v = 3'(rand_bits(3));
        if (v == 3'd7) begin
            v = 3'd0;
        end
        return mdu_op_e'(v);
    endfunction

    // ------------------------------------------------------------------
    // checking and run control
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %0h expected %0h", name, got, want);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, results checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // handshake signals are settled by mid-cycle
    always @(negedge clk) begin
        if (!reset_i && !flush_i && result_valid_o && result_ready_i) begin
            if (order_q.size() == 0) begin
                errors++;
                $display("result with tag %0h arrived while none was pending", result_o.dest);
            end else begin
                exp_tag = order_q.pop_front();
                check("result_o.dest", 64'(result_o.dest), 64'(exp_tag));
                check("result_o.data", 64'(result_o.data), 64'(exp_data[exp_tag]));
                checked++;
            end
        end
    end

    task automatic wait_dispatch_ready();
        int n;
        n = 0;
        while (!dispatch_ready_o && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!dispatch_ready_o) begin
            errors++;
            $display("dispatch_ready_o never came back high");
            finish_run();
        end
    endtask

    task automatic wait_result_valid();
        int n;
        n = 0;
        while (!result_valid_o && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!result_valid_o) begin
            errors++;
            $display("no result showed up");
            finish_run();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (order_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (order_q.size() != 0) begin
            errors++;
            $display("%0d results still missing after the wait", order_q.size());
            finish_run();
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check("result_valid_o", 64'(result_valid_o), 64'(0));
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    function automatic operand_t rdy(word_t v);
        operand_t o;
        o.ready = 1'b1;
        o.tag   = '0;
        o.value = v;
        return o;
    endfunction

    function automatic operand_t pending(rob_id_t t);
        operand_t o;
        o.ready = 1'b0;
        o.tag   = t;
        o.value = '0;
        return o;
    endfunction

    // a and b are the operand values the instruction ends up with
    task automatic new_op(input mdu_op_e op, input operand_t s0, input operand_t s1,
                          input word_t a, input word_t b, output disp_pkt_t p);
        p.valid  = 1'b1;
        p.op     = op;
        p.dest   = next_tag;
        p.src[0] = s0;
        p.src[1] = s1;
        exp_data[next_tag] = ref_result(op, a, b);
        order_q.push_back(next_tag);
        next_tag++;
    endtask

    task automatic ready_op(input mdu_op_e op, input word_t a, input word_t b,
                            output disp_pkt_t p);
        new_op(op, rdy(a), rdy(b), a, b, p);
    endtask

    task automatic random_op(input bit mul_only, output disp_pkt_t p);
        mdu_op_e op;
        word_t   a;
        word_t   b;
        op = mul_only ? OP_MUL : rand_op();
        a  = rand_bits(32);
        b  = rand_bits(32);
        ready_op(op, a, b, p);
    endtask

    task automatic send(input disp_pkt_t p0, input disp_pkt_t p1,
                        input cdb_t [CDB_COUNT-1:0] c);
        wait_dispatch_ready();
        disp_i[0] = p0;
        disp_i[1] = p1;
        cdb_i     = c;
        @(posedge clk);
        #1;
        disp_i = '0;
        cdb_i  = '0;
    endtask

    task automatic run_one(input mdu_op_e op, input word_t a, input word_t b);
        disp_pkt_t p;
        ready_op(op, a, b, p);
        send(p, '0, '0);
    endtask

    task automatic broadcast(input int port, input rob_id_t tag, input word_t v);
        cdb_i[port].valid = 1'b1;
        cdb_i[port].tag   = tag;
        cdb_i[port].data  = v;
        @(posedge clk);
        #1;
        cdb_i = '0;
    endtask

    // ------------------------------------------------------------------
    // tests
    task automatic test_single_ops();
        $display("test: single ops");
        run_one(OP_MUL, 32'hffff_fff9, 32'd6);
        run_one(OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
        run_one(OP_MULH, 32'h8000_0000, 32'h8000_0000);
        run_one(OP_MULH, 32'hffff_fffd, 32'd5);
        run_one(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        run_one(OP_DIV, 32'hffff_fff9, 32'd2);
        run_one(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_one(OP_DIVU, 32'hffff_fff9, 32'd2);
        run_one(OP_MOD, 32'hffff_fff9, 32'd2);
        run_one(OP_MOD, 32'd7, 32'hffff_fffe);
        run_one(OP_MODU, 32'hffff_ffff, 32'd10);
        wait_drain();
    endtask

    task automatic test_dual_dispatch();
        disp_pkt_t p0;
        disp_pkt_t p1;
        int        pairs;
        $display("test: dual dispatch");
        pairs = 0;
        while (dispatch_ready_o && pairs < 12) begin
            random_op(1'b0, p0);
            random_op(1'b0, p1);
            send(p0, p1, '0);
            pairs++;
        end
        check("dispatch_ready_o", 64'(dispatch_ready_o), 64'(0));
        wait_drain();
    endtask

    task automatic test_cdb_wakeup();
        disp_pkt_t            p;
        word_t                a;
        word_t                b;
        cdb_t [CDB_COUNT-1:0] c;
        $display("test: cdb wakeup");
        a = rand_bits(32);
        b = rand_bits(32);
        new_op(OP_MUL, pending(6'd40), rdy(b), a, b, p);
        send(p, '0, '0);
        expect_idle(8);
        broadcast(1, 6'd40, a);
        wait_drain();

        // both sources late, one per port
        // long enough for a divide that left too early to surface
        a = rand_bits(32);
        b = rand_bits(32);
        new_op(OP_DIVU, pending(6'd41), pending(6'd42), a, b, p);
        send(p, '0, '0);
        expect_idle(40);
        broadcast(0, 6'd41, a);
        expect_idle(40);
        broadcast(1, 6'd42, b);
        wait_drain();

        // value on the cdb in the dispatch cycle itself
        new_op(OP_MULH, rdy(a), pending(6'd43), a, b, p);
        c          = '0;
        c[0].valid = 1'b1;
        c[0].tag   = 6'd43;
        c[0].data  = b;
        send(p, '0, c);
        wait_drain();
    endtask

    task automatic test_div_by_zero();
        $display("test: division by zero");
        run_one(OP_DIV, 32'hffff_ff85, 32'd0);
        run_one(OP_DIVU, 32'h1234_5678, 32'd0);
        run_one(OP_MOD, 32'h8000_0001, 32'd0);
        run_one(OP_MODU, 32'h0bad_f00d, 32'd0);
        wait_drain();
    endtask

    task automatic test_back_pressure();
        disp_pkt_t p0;
        disp_pkt_t p1;
        mdu_res_t  held;
        int        pairs;
        $display("test: back-pressure");
        result_ready_i = 1'b0;
        pairs = 0;
        while (dispatch_ready_o && pairs < 12) begin
            random_op(1'b1, p0);
            random_op(1'b1, p1);
            send(p0, p1, '0);
            pairs++;
        end
        check("dispatch_ready_o", 64'(dispatch_ready_o), 64'(0));
        wait_result_valid();
        held = result_o;
        repeat (12) begin
            @(posedge clk);
            #1;
            check("result_valid_o", 64'(result_valid_o), 64'(1));
            check("result_o", 64'(result_o), 64'(held));
            check("dispatch_ready_o", 64'(dispatch_ready_o), 64'(0));
        end
        result_ready_i = 1'b1;
        wait_drain();
    endtask

    task automatic test_flush();
        disp_pkt_t p0;
        disp_pkt_t p1;
        int        pairs;
        $display("test: flush");
        // output stalled so every stage holds work when the flush hits
        result_ready_i = 1'b0;
        ready_op(OP_DIV, 32'h7654_3210, 32'd3, p0);
        ready_op(OP_DIVU, 32'hfedc_ba98, 32'd7, p1);
        send(p0, p1, '0);
        pairs = 1;
        while (dispatch_ready_o && pairs < 12) begin
            random_op(1'b0, p0);
            random_op(1'b0, p1);
            send(p0, p1, '0);
            pairs++;
        end
        wait_result_valid();
        check("dispatch_ready_o", 64'(dispatch_ready_o), 64'(0));
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i        = 1'b0;
        result_ready_i = 1'b1;
        // flushed work never comes back
        order_q.delete();
        check("result_valid_o", 64'(result_valid_o), 64'(0));
        check("dispatch_ready_o", 64'(dispatch_ready_o), 64'(1));
        run_one(OP_MUL, 32'hffff_fffe, 32'd21);
        run_one(OP_MOD, 32'hffff_ff9c, 32'd7);
        wait_drain();
    endtask

    initial begin
        clk            = 1'b0;
        reset_i        = 1'b1;
        flush_i        = 1'b0;
        disp_i         = '0;
        cdb_i          = '0;
        result_ready_i = 1'b1;
        lfsr_q         = 32'h3da970ba;
        next_tag       = '0;
        errors         = 0;
        checked        = 0;
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        test_single_ops();
        test_dual_dispatch();
        test_cdb_wakeup();
        test_div_by_zero();
        test_back_pressure();
        test_flush();

        if (order_q.size() != 0) begin
            errors++;
            $display("%0d results never arrived", order_q.size());
        end
        finish_run();
    end

endmodule

// ==== verilog.f ====
logic/mdu_pkg.sv
logic/mdu_iq_entry.sv
logic/mdu_issue_queue.sv
logic/mdu_op_decode.sv
logic/mdu_execute.sv
logic/mdu_result.sv
logic/mdu_top.sv
dv/mdu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, then judge the simulation log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mdu_tb -f verilog.f -o mdu_sim \
    > build.log 2>&1 && ./obj_dir/mdu_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
exit 0
